//--- logic/fetch_pkg.sv
package fetch_pkg;

    // Package defaults, overridden through the top level parameters
    localparam int PC_SIZE    = 32;                   // Program counter width in bits
    localparam int WORD_BYTES = 4;                    // Bytes per instruction word
    localparam int MEM_WORDS  = 16;                   // Depth of the instruction memory

    // Width of one instruction word in bits
    localparam int WORD_BITS  = WORD_BYTES * 8;

    // Pointer width, enough for memories up to 255 words
    localparam int PTR_BITS   = 8;

    // Program counter value
    typedef logic [PC_SIZE-1:0]   pc_t;

    // One instruction word as stored and fetched
    typedef logic [WORD_BITS-1:0] word_t;

    // Write pointer and fill count of the memory
    typedef logic [PTR_BITS-1:0]  mem_ptr_t;

endpackage

//--- logic/fetch_ctrl_if.sv
`timescale 1ns/100ps

interface fetch_ctrl_if;

    logic halt;                                       // Stop the program
    logic not_load;                                   // Stall request from the hazard unit
    logic enable;                                     // Run
    logic flush;                                      // Restart at PC 0, squash fetched word
    logic clear;                                      // Reset memory contents and PC

    // Top level drives all control levels
    modport driver (
        output halt,
        output not_load,
        output enable,
        output flush,
        output clear
    );

    // PC register needs the full set
    modport pc (
        input  halt,
        input  not_load,
        input  enable,
        input  flush,
        input  clear
    );

    // Pipeline register ignores clear
    modport stage (
        input  halt,
        input  not_load,
        input  enable,
        input  flush
    );

endinterface

//--- logic/program_counter.sv
`timescale 1ns/100ps

module program_counter
    import fetch_pkg::*;
#(
    parameter int PC_SIZE = fetch_pkg::PC_SIZE        // Width of the PC register
) (
    input  logic           i_clk,                     // System clock
    input  logic           i_rst_n,                   // Async reset, active low
    fetch_ctrl_if.pc       ctrl,                      // Pipeline control levels
    input  pc_t            i_next_pc,                 // PC selected for the next cycle
    output pc_t            o_pc                       // Present PC
);

    logic [PC_SIZE-1:0] pc_q;                         // PC register
    logic               advance;                      // PC moves on this edge
    logic               restart;                      // Flush or clear forces PC to zero
    logic               pc_aligned;                   // Present PC on a word boundary
    logic               next_aligned;                 // Next PC on a word boundary

    assign restart = ctrl.flush || ctrl.clear;        // Highest priority
    assign advance = ctrl.enable && !ctrl.halt && !ctrl.not_load;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            pc_q <= '0;                               // Program starts at address 0
        end else if (restart) begin
            pc_q <= '0;
        end else if (advance) begin
            pc_q <= i_next_pc;                        // Sequential or jump target
        end
        // Otherwise hold under halt, stall or disable
    end

    assign o_pc = pc_q;

    // Alignment checks against the word size from the package
    assign pc_aligned   = (pc_q % pc_t'(WORD_BYTES)) == '0;
    assign next_aligned = (i_next_pc % pc_t'(WORD_BYTES)) == '0;

    // An aligned PC fed an aligned next PC can never leave the word grid
    property p_pc_stays_aligned;
        @(posedge i_clk) disable iff (!i_rst_n)
            (pc_aligned && next_aligned) |=> pc_aligned;
    endproperty

    a_pc_stays_aligned: assert property (p_pc_stays_aligned)
        else $error("PC left word alignment: %h", pc_q);

endmodule

//--- logic/instruction_memory.sv
`timescale 1ns/100ps

module instruction_memory
    import fetch_pkg::*;
#(
    parameter int WORD_BYTES = fetch_pkg::WORD_BYTES, // Bytes per word, sets address step
    parameter int MEM_WORDS  = fetch_pkg::MEM_WORDS   // Number of stored words
) (
    input  logic     i_clk,                           // System clock
    input  logic     i_rst_n,                         // Async reset, active low
    input  logic     i_write,                         // Write strobe, one word per cycle
    input  logic     i_clear,                         // Empty memory and zero contents
    input  word_t    i_word,                          // Word to store
    input  pc_t      i_pc,                            // Byte address of the fetch
    output word_t    o_word,                          // Fetched word, zero when out of range
    output logic     o_full,                          // All MEM_WORDS entries written
    output logic     o_empty                          // Nothing written yet
);

    // Index width, at least one bit for a single word memory
    localparam int ADDR_W = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;

    // Pointer value at which the memory is full
    localparam mem_ptr_t FULL_PTR = mem_ptr_t'(MEM_WORDS);

    word_t              mem [MEM_WORDS];              // Instruction storage
    mem_ptr_t           wr_ptr;                       // Next free entry and fill count
    logic               wr_en;                        // Accepted write this cycle
    pc_t                rd_idx;                       // Word index from the byte address
    logic               rd_in_range;                  // Index falls inside the array
    logic [ADDR_W-1:0]  rd_addr;                      // Truncated read index
    logic [ADDR_W-1:0]  wr_addr;                      // Truncated write index

    assign o_full  = (wr_ptr == FULL_PTR);
    assign o_empty = (wr_ptr == '0);
    assign wr_en   = i_write && !o_full;              // Writes while full are dropped
    assign wr_addr = wr_ptr[ADDR_W-1:0];

    // Pointer control
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            wr_ptr <= '0;
        end else if (i_clear) begin
            wr_ptr <= '0;                             // Clear wins over a write
        end else if (wr_en) begin
            wr_ptr <= wr_ptr + mem_ptr_t'(1);
        end
    end

    // Storage array, contents only touched by clear and write
    always_ff @(posedge i_clk) begin
        if (i_clear) begin
            for (int i = 0; i < MEM_WORDS; i++) begin
                mem[i] <= '0;
            end
        end else if (wr_en) begin
            mem[wr_addr] <= i_word;
        end
    end

    // Asynchronous read, byte address to word index
    assign rd_idx      = i_pc / pc_t'(WORD_BYTES);
    assign rd_in_range = (rd_idx < pc_t'(MEM_WORDS));
    assign rd_addr     = rd_idx[ADDR_W-1:0];
    assign o_word      = rd_in_range ? mem[rd_addr] : '0;  // Past the end reads zero

    // Loader overran the memory, the word is lost
    property p_no_write_when_full;
        @(posedge i_clk) disable iff (!i_rst_n)
            (i_write && !i_clear) |-> !o_full;
    endproperty

    a_no_write_when_full: assert property (p_no_write_when_full)
        else $warning("Write dropped, instruction memory full");

    // Flags are exclusive for any nonzero depth
    property p_flags_exclusive;
        @(posedge i_clk) disable iff (!i_rst_n)
            !(o_full && o_empty);
    endproperty

    a_flags_exclusive: assert property (p_flags_exclusive)
        else $error("Memory reports full and empty together");

endmodule

//--- logic/fetch_stage.sv
`timescale 1ns/100ps

module fetch_stage
    import fetch_pkg::*;
#(
    parameter int PC_SIZE    = fetch_pkg::PC_SIZE,    // PC width
    parameter int WORD_BYTES = fetch_pkg::WORD_BYTES, // PC step in bytes
    parameter int MEM_WORDS  = fetch_pkg::MEM_WORDS   // Instruction memory depth
) (
    input  logic      i_clk,                          // System clock
    input  logic      i_rst_n,                        // Async reset, active low
    fetch_ctrl_if.pc  ctrl,                           // Pipeline control levels
    input  logic      i_next_pc_src,                  // 1 selects the non-sequential PC
    input  pc_t       i_next_not_seq_pc,              // Jump or branch target
    input  logic      i_write_mem,                    // Memory load strobe
    input  word_t     i_word,                         // Word to load
    output logic      o_full_mem,                     // Memory full
    output logic      o_empty_mem,                    // Memory empty
    output word_t     o_word,                         // Word at the present PC
    output pc_t       o_next_seq_pc,                  // Present PC plus one word
    output pc_t       o_current_pc                    // Present PC
);

    pc_t next_seq_pc;                                 // Sequential successor
    pc_t next_pc;                                     // Value the PC loads when advancing
    pc_t pc;                                          // PC register output

    // Increment wraps modulo 2^PC_SIZE
    assign next_seq_pc = pc + pc_t'(WORD_BYTES);

    // Two way next PC select
    assign next_pc = i_next_pc_src ? i_next_not_seq_pc : next_seq_pc;

    assign o_next_seq_pc = next_seq_pc;
    assign o_current_pc  = pc;

    program_counter #(
        .PC_SIZE   (PC_SIZE)
    ) pc_unit (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .ctrl      (ctrl),
        .i_next_pc (next_pc),
        .o_pc      (pc)
    );

    // Read port follows the present PC, clear comes from the control bus
    instruction_memory #(
        .WORD_BYTES (WORD_BYTES),
        .MEM_WORDS  (MEM_WORDS)
    ) imem_unit (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_write    (i_write_mem),
        .i_clear    (ctrl.clear),
        .i_word     (i_word),
        .i_pc       (pc),
        .o_word     (o_word),
        .o_full     (o_full_mem),
        .o_empty    (o_empty_mem)
    );

endmodule

//--- logic/if_id_register.sv
`timescale 1ns/100ps

module if_id_register
    import fetch_pkg::*;
(
    input  logic          i_clk,                      // System clock
    input  logic          i_rst_n,                    // Async reset, active low
    fetch_ctrl_if.stage   ctrl,                       // Stall, run and flush levels
    input  word_t         i_word,                     // Word fetched this cycle
    input  pc_t           i_next_seq_pc,              // Its sequential successor
    output word_t         o_word,                     // Word handed to decode
    output pc_t           o_next_seq_pc               // PC plus one word handed to decode
);

    word_t word_q;                                    // Registered instruction
    pc_t   seq_pc_q;                                  // Registered sequential PC
    logic  advance;                                   // Same condition that moves the PC

    // Kept identical to the PC rule so both stall together
    assign advance = ctrl.enable && !ctrl.halt && !ctrl.not_load;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            word_q   <= '0;
            seq_pc_q <= '0;
        end else if (ctrl.flush) begin
            word_q   <= '0;                           // Bubble into decode
            seq_pc_q <= '0;
        end else if (advance) begin
            word_q   <= i_word;
            seq_pc_q <= i_next_seq_pc;
        end
        // Hold on stall, nothing is lost
    end

    assign o_word        = word_q;
    assign o_next_seq_pc = seq_pc_q;

endmodule

//--- logic/fetch_top.sv
`timescale 1ns/100ps

module fetch_top
    import fetch_pkg::*;
#(
    parameter int PC_SIZE    = fetch_pkg::PC_SIZE,    // PC width
    parameter int WORD_BYTES = fetch_pkg::WORD_BYTES, // Bytes per word
    parameter int MEM_WORDS  = fetch_pkg::MEM_WORDS   // Instruction memory depth
) (
    input  logic   i_clk,                             // System clock
    input  logic   i_rst_n,                           // Async reset, active low
    input  logic   i_halt,                            // Stop the program
    input  logic   i_not_load,                        // Stall from the hazard unit
    input  logic   i_enable,                          // Run
    input  logic   i_next_pc_src,                     // Take the non-sequential PC
    input  logic   i_write_mem,                       // Memory load strobe
    input  logic   i_clear_mem,                       // Clear memory and PC
    input  logic   i_flush,                           // Restart at 0, squash fetched word
    input  word_t  i_instruction,                     // Word to load into memory
    input  pc_t    i_next_not_seq_pc,                 // Jump or branch target
    output logic   o_full_mem,                        // Memory full
    output logic   o_empty_mem,                       // Memory empty
    output word_t  o_instruction,                     // Registered word for decode
    output pc_t    o_next_seq_pc,                     // Registered PC plus one word
    output pc_t    o_current_pc                       // Present PC
);

    word_t fetched_word;                              // Memory read at the present PC
    pc_t   next_seq_pc;                               // Present PC plus one word

    fetch_ctrl_if ctrl_bus ();                        // Control levels shared by both blocks

    // Plain ports onto the control bus
    assign ctrl_bus.halt     = i_halt;
    assign ctrl_bus.not_load = i_not_load;
    assign ctrl_bus.enable   = i_enable;
    assign ctrl_bus.flush    = i_flush;
    assign ctrl_bus.clear    = i_clear_mem;

    fetch_stage #(
        .PC_SIZE           (PC_SIZE),
        .WORD_BYTES        (WORD_BYTES),
        .MEM_WORDS         (MEM_WORDS)
    ) fetch_stage_inst (
        .i_clk             (i_clk),
        .i_rst_n           (i_rst_n),
        .ctrl              (ctrl_bus.pc),
        .i_next_pc_src     (i_next_pc_src),
        .i_next_not_seq_pc (i_next_not_seq_pc),
        .i_write_mem       (i_write_mem),
        .i_word            (i_instruction),
        .o_full_mem        (o_full_mem),
        .o_empty_mem       (o_empty_mem),
        .o_word            (fetched_word),
        .o_next_seq_pc     (next_seq_pc),
        .o_current_pc      (o_current_pc)
    );

    // Fetch to decode boundary
    if_id_register if_id_inst (
        .i_clk             (i_clk),
        .i_rst_n           (i_rst_n),
        .ctrl              (ctrl_bus.stage),
        .i_word            (fetched_word),
        .i_next_seq_pc     (next_seq_pc),
        .o_word            (o_instruction),
        .o_next_seq_pc     (o_next_seq_pc)
    );

endmodule

//--- bench/clock_gen.sv
`timescale 1ns/100ps

module clock_gen #(
    parameter int PERIOD_NS    = 4,                   // Clock period
    parameter int RESET_CYCLES = 8                    // Rising edges spent in reset
) (
    output logic o_clk,                               // Free running clock
    output logic o_rst_n                              // Active low reset
);

    initial begin
        o_clk = 1'b0;
        forever #(PERIOD_NS / 2.0) o_clk = ~o_clk;
    end

    // Release 1 ns after an edge, same offset as the stimulus
    initial begin
        o_rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge o_clk);
        #1 o_rst_n = 1'b1;
    end

endmodule

//--- bench/fetch_tb.sv
`timescale 1ns/100ps

module fetch_tb
    import fetch_pkg::*;
#(
    parameter int TB_MEM_WORDS = MEM_WORDS            // Memory depth built into the DUT
);

    localparam int CLK_PERIOD   = 4;                  // ns
    localparam int RESET_CYCLES = 8;
    localparam int SEQ_CYCLES   = TB_MEM_WORDS + 4;   // Runs past the end of memory
    localparam int JUMP_CYCLES  = 40;
    localparam int STALL_CYCLES = 60;
    localparam int FLUSH_RUN    = 6;
    localparam int CLEAR_RUN    = TB_MEM_WORDS + 2;
    localparam int TOTAL_CYCLES = RESET_CYCLES + 1 + (TB_MEM_WORDS + 1) + SEQ_CYCLES
                                + JUMP_CYCLES + STALL_CYCLES + 1 + FLUSH_RUN + 1
                                + CLEAR_RUN + 1;
    localparam int MARGIN       = 20;                 // Spare cycles before the watchdog fires

    logic  clk, rst_n;
    logic  halt, not_load, enable, next_pc_src, write_mem, clear_mem, flush;
    word_t instruction;
    pc_t   next_not_seq_pc;
    logic  full_mem, empty_mem;
    word_t instr_out;
    pc_t   next_seq_pc, current_pc;

    word_t        model_mem [TB_MEM_WORDS];           // Expected memory contents
    int           model_ptr;                          // Expected write pointer
    pc_t          model_pc;                           // Expected present PC
    word_t        model_word;                         // Expected decode word
    pc_t          model_seq;                          // Expected decode sequential PC
    logic [31:0]  rng;                                // LCG state

    clock_gen #(.PERIOD_NS(CLK_PERIOD), .RESET_CYCLES(RESET_CYCLES)) clk_inst (
        .o_clk   (clk),
        .o_rst_n (rst_n)
    );

    fetch_top #(
        .PC_SIZE           (PC_SIZE),
        .WORD_BYTES        (WORD_BYTES),
        .MEM_WORDS         (TB_MEM_WORDS)
    ) fetch_top_inst (
        .i_clk             (clk),
        .i_rst_n           (rst_n),
        .i_halt            (halt),
        .i_not_load        (not_load),
        .i_enable          (enable),
        .i_next_pc_src     (next_pc_src),
        .i_write_mem       (write_mem),
        .i_clear_mem       (clear_mem),
        .i_flush           (flush),
        .i_instruction     (instruction),
        .i_next_not_seq_pc (next_not_seq_pc),
        .o_full_mem        (full_mem),
        .o_empty_mem       (empty_mem),
        .o_instruction     (instr_out),
        .o_next_seq_pc     (next_seq_pc),
        .o_current_pc      (current_pc)
    );

    function automatic logic [31:0] lcg_next(logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;  // Numerical Recipes constants
    endfunction

    // Word the memory should return at a byte address
    function automatic word_t model_fetch(pc_t pc);
        pc_t idx;
        idx = pc / WORD_BYTES;
        if (idx < TB_MEM_WORDS) return model_mem[idx];
        else return '0;                               // Out of range reads zero
    endfunction

    // PC after one edge with restart over advance over hold
    function automatic pc_t model_next_pc(pc_t pc, logic restart, logic advance,
                                          logic src, pc_t target);
        if (restart) return '0;
        else if (advance) return src ? target : pc + pc_t'(WORD_BYTES);
        else return pc;
    endfunction

    task automatic report_failure(string reason);
        $display("%s", reason);
        $display("TEST RESULT: FAIL");
        $fatal(1, "Simulation stopped on first error");
    endtask

    task automatic check_pc(string name, pc_t got, pc_t exp);
        if (got !== exp) begin
            report_failure($sformatf("Fail %s: got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_word(string name, word_t got, word_t exp);
        if (got !== exp) begin
            report_failure($sformatf("Fail %s: got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_flag(string name, logic got, logic exp);
        if (got !== exp) begin
            report_failure($sformatf("Fail %s: got %h expected %h", name, got, exp));
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;                                           // Drive point after the edge
    endtask

    // Reference model updated on the same edge as the DUT
    always @(posedge clk or negedge rst_n) begin : model_update
        pc_t   old_pc;
        word_t fetched;
        logic  advance;
        if (!rst_n) begin
            model_ptr  = 0;
            model_pc   = '0;
            model_word = '0;
            model_seq  = '0;
        end else begin
            old_pc  = model_pc;
            fetched = model_fetch(old_pc);            // Memory as it was before this edge
            advance = enable && !halt && !not_load;
            if (flush) begin
                model_word = '0;                      // Bubble
                model_seq  = '0;
            end else if (advance) begin
                model_word = fetched;
                model_seq  = old_pc + pc_t'(WORD_BYTES);
            end
            model_pc = model_next_pc(old_pc, flush || clear_mem, advance,
                                     next_pc_src, next_not_seq_pc);
            if (clear_mem) begin
                for (int i = 0; i < TB_MEM_WORDS; i++) model_mem[i] = '0;
                model_ptr = 0;
            end else if (write_mem && model_ptr < TB_MEM_WORDS) begin
                model_mem[model_ptr] = instruction;
                model_ptr++;
            end
        end
    end

    // Compare half a nanosecond after each edge and before the next drive
    always @(posedge clk) begin
        if (rst_n) begin
            #0.5;
            check_pc("o_current_pc", current_pc, model_pc);
            check_word("o_instruction", instr_out, model_word);
            check_pc("o_next_seq_pc", next_seq_pc, model_seq);
            check_flag("o_full_mem", full_mem, model_ptr == TB_MEM_WORDS);
            check_flag("o_empty_mem", empty_mem, model_ptr == 0);
        end
    end

    initial begin : watchdog
        #((TOTAL_CYCLES + MARGIN) * CLK_PERIOD);
        report_failure("Timeout, the run did not finish within the scheduled cycles");
    end

    initial begin : stimulus
        halt = 1'b0;
        not_load = 1'b0;
        enable = 1'b0;
        next_pc_src = 1'b0;
        write_mem = 1'b0;
        clear_mem = 1'b0;
        flush = 1'b0;
        instruction = '0;
        next_not_seq_pc = '0;
        rng = 32'hedfc;
        @(posedge rst_n);
        next_cycle();
        check_flag("o_empty_mem", empty_mem, 1'b1);
        check_flag("o_full_mem", full_mem, 1'b0);

        write_mem = 1'b1;                             // Fill the memory plus one dropped write
        repeat (TB_MEM_WORDS + 1) begin
            rng = lcg_next(rng);
            instruction = rng;
            next_cycle();
        end
        write_mem = 1'b0;
        check_flag("o_full_mem", full_mem, 1'b1);

        enable = 1'b1;                                // Straight line fetch
        repeat (SEQ_CYCLES) next_cycle();

        repeat (JUMP_CYCLES) begin
            rng = lcg_next(rng);
            next_pc_src = rng[20];
            rng = lcg_next(rng);
            next_not_seq_pc = pc_t'((rng[23:16] % (TB_MEM_WORDS + 4)) * WORD_BYTES);
            next_cycle();
        end

        repeat (STALL_CYCLES) begin
            rng = lcg_next(rng);
            halt = (rng[17:16] == 2'd1);
            not_load = (rng[17:16] == 2'd2);
            enable = (rng[17:16] != 2'd3);
            next_pc_src = rng[24];
            next_not_seq_pc = pc_t'((rng[31:28] % TB_MEM_WORDS) * WORD_BYTES);
            next_cycle();
        end
        halt = 1'b0;
        not_load = 1'b0;
        enable = 1'b1;
        next_pc_src = 1'b0;

        flush = 1'b1;
        next_cycle();
        flush = 1'b0;
        check_pc("o_current_pc", current_pc, '0);
        check_word("o_instruction", instr_out, '0);
        check_pc("o_next_seq_pc", next_seq_pc, '0);
        repeat (FLUSH_RUN) next_cycle();

        clear_mem = 1'b1;
        next_cycle();
        clear_mem = 1'b0;
        check_pc("o_current_pc", current_pc, '0);
        check_flag("o_empty_mem", empty_mem, 1'b1);
        repeat (CLEAR_RUN) begin
            next_cycle();
            check_word("o_instruction", instr_out, '0);  // Cleared memory reads zero
            check_flag("o_empty_mem", empty_mem, 1'b1);
        end
        next_cycle();

        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

//--- filelist.f
logic/fetch_pkg.sv
logic/fetch_ctrl_if.sv
logic/program_counter.sv
logic/instruction_memory.sv
logic/fetch_stage.sv
logic/if_id_register.sv
logic/fetch_top.sv
bench/clock_gen.sv
bench/fetch_tb.sv
